// File: rtl/fabric_geom_pkg.sv
`default_nettype none

package fabric_geom_pkg;

	// ============================================================
	// routing geometry
	// ============================================================

	localparam int TRACKS = 4; // tracks per side

	// side numbering, west is the fabric edge
	localparam int SIDE_N = 0;
	localparam int SIDE_S = 1;
	localparam int SIDE_W = 2;
	localparam int SIDE_E = 3;

	localparam int SEL_W = 2; // one track selector

	// switch box: north, south, east outputs only
	localparam int SB_OUTS = 12;
	localparam int SB_CFG_W = SB_OUTS * SEL_W; // 24 bits

endpackage

`default_nettype wire

// File: rtl/fabric_cfg_pkg.sv
`default_nettype none

package fabric_cfg_pkg;

	// ============================================================
	// configuration bus
	// ============================================================

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	localparam int TILE_ID_W = 16; // addr[15:0]
	localparam int BLOCK_ID_W = 16; // addr[31:16]

	// block ids in the high address half
	localparam logic [BLOCK_ID_W-1:0] BLK_SB = 16'd7;
	localparam logic [BLOCK_ID_W-1:0] BLK_CB0 = 16'd6;
	localparam logic [BLOCK_ID_W-1:0] BLK_CB1 = 16'd5;
	localparam logic [BLOCK_ID_W-1:0] BLK_CLB = 16'd4;

	// ============================================================
	// logic block opcodes
	// ============================================================

	localparam int OP_W = 2;

	localparam logic [OP_W-1:0] OP_AND = 2'd0;
	localparam logic [OP_W-1:0] OP_OR = 2'd1;
	localparam logic [OP_W-1:0] OP_XOR = 2'd2;
	localparam logic [OP_W-1:0] OP_NAND = 2'd3;

endpackage

`default_nettype wire

// File: rtl/connect_box.sv
`timescale 1ns/1ps
`default_nettype none

module connect_box (
	input wire clk,
	input wire reset,
	input wire config_en,
	input wire [fabric_geom_pkg::SEL_W-1:0] config_data,
	input wire [fabric_geom_pkg::TRACKS-1:0] track_in,
	output logic block_out
);

	logic [fabric_geom_pkg::SEL_W-1:0] sel;

	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0; // track 0 after reset
		end else if (config_en) begin
			sel <= config_data;
		end
	end

	// 4:1 track mux
	assign block_out = track_in[sel];

endmodule

`default_nettype wire

// File: rtl/switch_box_left.sv
`timescale 1ns/1ps
`default_nettype none

module switch_box_left (
	input wire clk,
	input wire reset,
	input wire config_en,
	input wire [fabric_geom_pkg::SB_CFG_W-1:0] config_data,
	input wire [fabric_geom_pkg::TRACKS-1:0] in_wire_0,
	input wire [fabric_geom_pkg::TRACKS-1:0] in_wire_1,
	input wire [fabric_geom_pkg::TRACKS-1:0] in_wire_2,
	input wire [fabric_geom_pkg::TRACKS-1:0] in_wire_3,
	input wire pe_output,
	output logic [fabric_geom_pkg::TRACKS-1:0] out_wire_0,
	output logic [fabric_geom_pkg::TRACKS-1:0] out_wire_1,
	output logic [fabric_geom_pkg::TRACKS-1:0] out_wire_3
);

	// ============================================================
	// routing configuration
	// ============================================================

	logic [fabric_geom_pkg::SB_CFG_W-1:0] cfg;
	logic [fabric_geom_pkg::SB_OUTS-1:0][fabric_geom_pkg::SEL_W-1:0] sel;
	logic [fabric_geom_pkg::TRACKS-1:0] side_in [0:3];

	always_ff @(posedge clk) begin
		if (reset) begin
			cfg <= '0;
		end else if (config_en) begin
			cfg <= config_data;
		end
	end

	assign sel = cfg; // north 0..3, south 0..3, east 0..3

	assign side_in[fabric_geom_pkg::SIDE_N] = in_wire_0;
	assign side_in[fabric_geom_pkg::SIDE_S] = in_wire_1;
	assign side_in[fabric_geom_pkg::SIDE_W] = in_wire_2; // edge, input only
	assign side_in[fabric_geom_pkg::SIDE_E] = in_wire_3;

	// 0..2 pick the other sides in ascending order, 3 the logic output
	function automatic logic pick(
		input logic [fabric_geom_pkg::SEL_W-1:0] s,
		input logic src0,
		input logic src1,
		input logic src2,
		input logic pe
	);
		logic r;
		case (s)
			2'd0: r = src0;
			2'd1: r = src1;
			2'd2: r = src2;
			default: r = pe;
		endcase
		return r;
	endfunction

	// ============================================================
	// output muxes
	// ============================================================

	for (genvar t = 0; t < fabric_geom_pkg::TRACKS; t++) begin : g_track
		assign out_wire_0[t] = pick(sel[t],
			side_in[fabric_geom_pkg::SIDE_S][t],
			side_in[fabric_geom_pkg::SIDE_W][t],
			side_in[fabric_geom_pkg::SIDE_E][t],
			pe_output); // north

		assign out_wire_1[t] = pick(sel[fabric_geom_pkg::TRACKS + t],
			side_in[fabric_geom_pkg::SIDE_N][t],
			side_in[fabric_geom_pkg::SIDE_W][t],
			side_in[fabric_geom_pkg::SIDE_E][t],
			pe_output); // south

		assign out_wire_3[t] = pick(sel[2*fabric_geom_pkg::TRACKS + t],
			side_in[fabric_geom_pkg::SIDE_N][t],
			side_in[fabric_geom_pkg::SIDE_S][t],
			side_in[fabric_geom_pkg::SIDE_W][t],
			pe_output); // east
	end

endmodule

`default_nettype wire

// File: rtl/clb.sv
`timescale 1ns/1ps
`default_nettype none

module clb (
	input wire clk,
	input wire reset,
	input wire config_en,
	input wire [fabric_cfg_pkg::OP_W-1:0] config_data,
	input wire in0,
	input wire in1,
	output logic out
);

	logic [fabric_cfg_pkg::OP_W-1:0] opcode;
	logic res;

	always_ff @(posedge clk) begin
		if (reset) begin
			opcode <= fabric_cfg_pkg::OP_AND;
		end else if (config_en) begin
			opcode <= config_data;
		end
	end

	always_comb begin
		case (opcode)
			fabric_cfg_pkg::OP_OR: res = in0 | in1;
			fabric_cfg_pkg::OP_XOR: res = in0 ^ in1;
			fabric_cfg_pkg::OP_NAND: res = ~(in0 & in1);
			default: res = in0 & in1; // OP_AND
		endcase
	end

	// output register, one cycle latency
	always_ff @(posedge clk) begin
		if (reset) begin
			out <= 1'b0;
		end else begin
			out <= res;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pe_tile_left.sv
`timescale 1ns/1ps
`default_nettype none

module pe_tile_left #(
	parameter logic [fabric_cfg_pkg::TILE_ID_W-1:0] TILE_ID = 16'd0
) (
	input wire clk,
	input wire reset,
	input wire [fabric_cfg_pkg::ADDR_W-1:0] config_addr,
	input wire [fabric_cfg_pkg::DATA_W-1:0] config_data,
	input wire [fabric_geom_pkg::TRACKS-1:0] in_wire_0,
	input wire [fabric_geom_pkg::TRACKS-1:0] in_wire_1,
	input wire [fabric_geom_pkg::TRACKS-1:0] in_wire_2,
	input wire [fabric_geom_pkg::TRACKS-1:0] in_wire_3,
	output wire [fabric_geom_pkg::TRACKS-1:0] out_wire_0,
	output wire [fabric_geom_pkg::TRACKS-1:0] out_wire_1,
	output wire [fabric_geom_pkg::TRACKS-1:0] out_wire_3
);

	// ============================================================
	// configuration decode
	// ============================================================

	logic tile_hit;
	logic [fabric_cfg_pkg::BLOCK_ID_W-1:0] block_id;
	logic config_en_sb;
	logic config_en_cb0;
	logic config_en_cb1;
	logic config_en_clb;

	wire op_0;
	wire op_1;
	wire pe_output;

	assign tile_hit = (config_addr[fabric_cfg_pkg::TILE_ID_W-1:0] == TILE_ID);
	assign block_id = config_addr[fabric_cfg_pkg::TILE_ID_W +: fabric_cfg_pkg::BLOCK_ID_W];

	assign config_en_sb = tile_hit && (block_id == fabric_cfg_pkg::BLK_SB);
	assign config_en_cb0 = tile_hit && (block_id == fabric_cfg_pkg::BLK_CB0);
	assign config_en_cb1 = tile_hit && (block_id == fabric_cfg_pkg::BLK_CB1);
	assign config_en_clb = tile_hit && (block_id == fabric_cfg_pkg::BLK_CLB);

	// ============================================================
	// blocks
	// ============================================================

	connect_box cb0 (
		.clk(clk),
		.reset(reset),
		.config_en(config_en_cb0),
		.config_data(config_data[fabric_geom_pkg::SEL_W-1:0]),
		.track_in(in_wire_0), // north tracks
		.block_out(op_0)
	);

	connect_box cb1 (
		.clk(clk),
		.reset(reset),
		.config_en(config_en_cb1),
		.config_data(config_data[fabric_geom_pkg::SEL_W-1:0]),
		.track_in(in_wire_1), // south tracks
		.block_out(op_1)
	);

	clb compute_block (
		.clk(clk),
		.reset(reset),
		.config_en(config_en_clb),
		.config_data(config_data[fabric_cfg_pkg::OP_W-1:0]),
		.in0(op_0),
		.in1(op_1),
		.out(pe_output)
	);

	switch_box_left sb (
		.clk(clk),
		.reset(reset),
		.config_en(config_en_sb),
		.config_data(config_data[fabric_geom_pkg::SB_CFG_W-1:0]),
		.in_wire_0(in_wire_0),
		.in_wire_1(in_wire_1),
		.in_wire_2(in_wire_2),
		.in_wire_3(in_wire_3),
		.pe_output(pe_output),
		.out_wire_0(out_wire_0),
		.out_wire_1(out_wire_1),
		.out_wire_3(out_wire_3)
	);

endmodule

`default_nettype wire

// File: rtl/fabric_column.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_column (
	input wire clk,
	input wire reset,
	input wire [fabric_cfg_pkg::ADDR_W-1:0] config_addr,
	input wire [fabric_cfg_pkg::DATA_W-1:0] config_data,
	input wire [fabric_geom_pkg::TRACKS-1:0] north_in,
	input wire [fabric_geom_pkg::TRACKS-1:0] t0_west_in,
	input wire [fabric_geom_pkg::TRACKS-1:0] t1_west_in,
	input wire [fabric_geom_pkg::TRACKS-1:0] t0_east_in,
	input wire [fabric_geom_pkg::TRACKS-1:0] t1_east_in,
	input wire [fabric_geom_pkg::TRACKS-1:0] south_in,
	output wire [fabric_geom_pkg::TRACKS-1:0] north_out,
	output wire [fabric_geom_pkg::TRACKS-1:0] t0_east_out,
	output wire [fabric_geom_pkg::TRACKS-1:0] t1_east_out,
	output wire [fabric_geom_pkg::TRACKS-1:0] south_out
);

	wire [fabric_geom_pkg::TRACKS-1:0] t0_to_t1; // tile 0 south -> tile 1 north
	wire [fabric_geom_pkg::TRACKS-1:0] t1_to_t0; // tile 1 north -> tile 0 south

	// ============================================================
	// upper tile
	// ============================================================

	pe_tile_left #(
		.TILE_ID(16'd1)
	) tile_0 (
		.clk(clk),
		.reset(reset),
		.config_addr(config_addr),
		.config_data(config_data),
		.in_wire_0(north_in),
		.in_wire_1(t1_to_t0),
		.in_wire_2(t0_west_in),
		.in_wire_3(t0_east_in),
		.out_wire_0(north_out),
		.out_wire_1(t0_to_t1),
		.out_wire_3(t0_east_out)
	);

	// lower tile
	pe_tile_left #(
		.TILE_ID(16'd2)
	) tile_1 (
		.clk(clk),
		.reset(reset),
		.config_addr(config_addr),
		.config_data(config_data),
		.in_wire_0(t0_to_t1),
		.in_wire_1(south_in),
		.in_wire_2(t1_west_in),
		.in_wire_3(t1_east_in),
		.out_wire_0(t1_to_t0),
		.out_wire_1(south_out),
		.out_wire_3(t1_east_out)
	);

endmodule

`default_nettype wire

// File: verification/tb_fabric_column.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fabric_column;

	localparam logic [31:0] PARK_ADDR = 32'h0000_0000; // tile id 0 that no tile answers

	logic clk;
	logic reset;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [3:0] north_in;
	logic [3:0] t0_west_in;
	logic [3:0] t1_west_in;
	logic [3:0] t0_east_in;
	logic [3:0] t1_east_in;
	logic [3:0] south_in;
	wire [3:0] north_out;
	wire [3:0] t0_east_out;
	wire [3:0] t1_east_out;
	wire [3:0] south_out;

	// model state
	logic [23:0] m_sb [0:1];
	logic [1:0] m_cb0 [0:1];
	logic [1:0] m_cb1 [0:1];
	logic [1:0] m_op [0:1];
	logic [1:0] m_q; // one logic register bit per tile
	logic [3:0] e_north;
	logic [3:0] e_t0_east;
	logic [3:0] e_t1_east;
	logic [3:0] e_south;
	logic [3:0] e_up;
	logic [3:0] e_down;
	logic [1:0] e_res;
	logic want_valid;
	logic [3:0] want_east0;
	integer seed;
	int checks;
	int errors;

	fabric_column fabric_column_i (
		.clk(clk),
		.reset(reset),
		.config_addr(config_addr),
		.config_data(config_data),
		.north_in(north_in),
		.t0_west_in(t0_west_in),
		.t1_west_in(t1_west_in),
		.t0_east_in(t0_east_in),
		.t1_east_in(t1_east_in),
		.south_in(south_in),
		.north_out(north_out),
		.t0_east_out(t0_east_out),
		.t1_east_out(t1_east_out),
		.south_out(south_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ============================================================
	// reference model
	// ============================================================

	function automatic logic [31:0] rand32();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	function automatic logic [15:0] tile_id(input int tile);
		return (tile == 0) ? 16'd1 : 16'd2;
	endfunction

	// truth tables indexed by {a, b}
	function automatic logic apply_op(input logic [1:0] op, input logic a, input logic b);
		logic [3:0] table_bits;
		case (op)
			fabric_cfg_pkg::OP_AND: table_bits = 4'b1000;
			fabric_cfg_pkg::OP_OR: table_bits = 4'b1110;
			fabric_cfg_pkg::OP_XOR: table_bits = 4'b0110;
			fabric_cfg_pkg::OP_NAND: table_bits = 4'b0111;
			default: table_bits = 4'bxxxx;
		endcase
		return table_bits[{a, b}];
	endfunction

	// selects 0..2 walk the other sides in ascending order
	function automatic logic [3:0] route_side(input logic [23:0] cfg, input int side,
		input logic [3:0] n, input logic [3:0] s, input logic [3:0] w, input logic [3:0] e,
		input logic pe);
		logic [3:0] sides [0:3];
		logic [3:0] others [0:2];
		logic [3:0] r;
		logic [1:0] sel;
		int i;
		int k;
		int grp;
		sides[0] = n;
		sides[1] = s;
		sides[2] = w;
		sides[3] = e;
		k = 0;
		for (i = 0; i < 4; i++) begin
			if (i != side) begin
				others[k] = sides[i];
				k++;
			end
		end
		grp = (side == fabric_geom_pkg::SIDE_E) ? 2 : side; // no west group
		for (i = 0; i < 4; i++) begin
			sel = cfg[2*(grp*4 + i) +: 2];
			r[i] = (sel == 2'd3) ? pe : others[sel][i];
		end
		return r;
	endfunction

	task automatic eval_model;
		// tile 1 north never reads tile 1 north, so it goes first
		e_up = route_side(m_sb[1], fabric_geom_pkg::SIDE_N, 4'h0, south_in,
			t1_west_in, t1_east_in, m_q[1]);
		e_north = route_side(m_sb[0], fabric_geom_pkg::SIDE_N, north_in, e_up,
			t0_west_in, t0_east_in, m_q[0]);
		e_down = route_side(m_sb[0], fabric_geom_pkg::SIDE_S, north_in, e_up,
			t0_west_in, t0_east_in, m_q[0]);
		e_t0_east = route_side(m_sb[0], fabric_geom_pkg::SIDE_E, north_in, e_up,
			t0_west_in, t0_east_in, m_q[0]);
		e_south = route_side(m_sb[1], fabric_geom_pkg::SIDE_S, e_down, south_in,
			t1_west_in, t1_east_in, m_q[1]);
		e_t1_east = route_side(m_sb[1], fabric_geom_pkg::SIDE_E, e_down, south_in,
			t1_west_in, t1_east_in, m_q[1]);
		e_res[0] = apply_op(m_op[0], north_in[m_cb0[0]], e_up[m_cb1[0]]);
		e_res[1] = apply_op(m_op[1], e_down[m_cb0[1]], south_in[m_cb1[1]]);
	endtask

	// what the DUT does at a rising edge with the values it samples
	task automatic model_edge;
		logic [1:0] nxt;
		int i;
		if (reset) begin
			for (i = 0; i < 2; i++) begin
				m_sb[i] = '0;
				m_cb0[i] = '0;
				m_cb1[i] = '0;
				m_op[i] = '0;
			end
			m_q = 2'b00;
		end else begin
			eval_model();
			nxt = e_res;
			for (i = 0; i < 2; i++) begin
				if (config_addr[15:0] == tile_id(i)) begin
					case (config_addr[31:16])
						fabric_cfg_pkg::BLK_SB: m_sb[i] = config_data[23:0];
						fabric_cfg_pkg::BLK_CB0: m_cb0[i] = config_data[1:0];
						fabric_cfg_pkg::BLK_CB1: m_cb1[i] = config_data[1:0];
						fabric_cfg_pkg::BLK_CLB: m_op[i] = config_data[1:0];
						default: ;
					endcase
				end
			end
			m_q = nxt;
		end
	endtask

	// ============================================================
	// checks and stimulus
	// ============================================================

	task automatic check4(input string name, input logic [3:0] got, input logic [3:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_outputs;
		eval_model();
		check4("north_out", north_out, e_north);
		check4("t0_east_out", t0_east_out, e_t0_east);
		check4("t1_east_out", t1_east_out, e_t1_east);
		check4("south_out", south_out, e_south);
		check4("tile_0.pe_output", {3'b000, fabric_column_i.tile_0.pe_output},
			{3'b000, m_q[0]});
		check4("tile_1.pe_output", {3'b000, fabric_column_i.tile_1.pe_output},
			{3'b000, m_q[1]});
		if (want_valid) begin
			check4("t0_east_out", t0_east_out, want_east0);
		end
	endtask

	// check at the falling edge, then step the model on the rising edge
	task automatic run_cycle;
		@(negedge clk);
		compare_outputs();
		@(posedge clk);
		model_edge();
	endtask

	task automatic drive_random_inputs;
		logic [31:0] r;
		r = rand32();
		north_in <= r[3:0];
		t0_west_in <= r[7:4];
		t1_west_in <= r[11:8];
		t0_east_in <= r[15:12];
		t1_east_in <= r[19:16];
		south_in <= r[23:20];
	endtask

	task automatic write_cfg(input logic [15:0] tile, input logic [15:0] blk,
		input logic [31:0] data);
		config_addr <= {blk, tile};
		config_data <= data;
		run_cycle();
		config_addr <= PARK_ADDR;
		config_data <= rand32();
	endtask

	// keep tile 0 south and tile 1 north from feeding each other
	function automatic logic [23:0] avoid_loop(input int tile, input logic [23:0] cfg);
		logic [23:0] r;
		logic risky;
		int t;
		r = cfg;
		risky = 1'b0;
		for (t = 0; t < 4; t++) begin
			if (tile == 1 && m_sb[0][2*(4+t) +: 2] == 2'd0) begin
				risky = 1'b1;
			end
			if (tile == 0 && (m_sb[1][2*t +: 2] == 2'd0 || m_sb[1][2*t +: 2] == 2'd3)) begin
				risky = 1'b1;
			end
		end
		for (t = 0; t < 4; t++) begin
			if (risky && tile == 1 && (r[2*t +: 2] == 2'd0 || r[2*t +: 2] == 2'd3)) begin
				r[2*t +: 2] = 2'd1; // west instead
			end
			if (risky && tile == 0 && r[2*(4+t) +: 2] == 2'd0) begin
				r[2*(4+t) +: 2] = 2'd2; // east instead
			end
		end
		return r;
	endfunction

	task automatic finish_test(input int num, input string name, input int start);
		$display("test %0d %s: %0d errors", num, name, errors - start);
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		int k;
		int op;
		int sel;
		int start;
		int lat;
		logic seen;
		logic [31:0] r;
		logic [15:0] tile;
		logic [15:0] blk;
		seed = 32'h9597_a6b5;
		checks = 0;
		errors = 0;
		want_valid = 1'b0;
		want_east0 = 4'h0;
		reset <= 1'b1;
		config_addr <= PARK_ADDR;
		config_data <= 32'h0;
		north_in <= 4'h0;
		t0_west_in <= 4'h0;
		t1_west_in <= 4'h0;
		t0_east_in <= 4'h0;
		t1_east_in <= 4'h0;
		south_in <= 4'h0;
		repeat (8) begin
			@(posedge clk);
			model_edge();
		end
		reset <= 1'b0;

		start = errors;
		repeat (16) begin
			drive_random_inputs();
			run_cycle();
		end
		finish_test(1, "reset state", start);

		start = errors;
		for (k = 0; k < 12; k++) begin
			r = rand32();
			write_cfg(tile_id(k % 2), fabric_cfg_pkg::BLK_SB,
				{8'h00, avoid_loop(k % 2, r[23:0])});
			repeat (4) begin
				drive_random_inputs();
				run_cycle();
			end
		end
		finish_test(2, "switch routing", start);

		start = errors;
		write_cfg(16'd1, fabric_cfg_pkg::BLK_SB, 32'h00ff_5555); // east from logic
		write_cfg(16'd2, fabric_cfg_pkg::BLK_SB, 32'h0000_0000);
		for (op = 0; op < 4; op++) begin
			for (sel = 0; sel < 4; sel++) begin
				write_cfg(16'd1, fabric_cfg_pkg::BLK_CLB, {30'd0, op[1:0]});
				write_cfg(16'd1, fabric_cfg_pkg::BLK_CB0, {30'd0, sel[1:0]});
				write_cfg(16'd1, fabric_cfg_pkg::BLK_CB1, {30'd0, sel[1:0]});
				repeat (4) begin
					drive_random_inputs();
					run_cycle();
					want_east0 = {4{apply_op(op[1:0], north_in[sel[1:0]], south_in[sel[1:0]])}};
					want_valid = 1'b1;
				end
				run_cycle();
				want_valid = 1'b0;
			end
		end
		finish_test(3, "opcodes", start);

		start = errors;
		repeat (24) begin
			r = rand32();
			if (r[1:0] == 2'd0) begin
				tile = 16'd3;
			end else if (r[1:0] == 2'd1) begin
				tile = 16'd0;
			end else begin
				tile = r[2] ? 16'd2 : 16'd1;
			end
			blk = 16'd4 + {14'd0, r[4:3]};
			if (tile == 16'd1 || tile == 16'd2) begin
				blk = r[31:16];
				if (blk >= 16'd4 && blk <= 16'd7) blk = blk ^ 16'h8000; // unused id
			end
			drive_random_inputs();
			write_cfg(tile, blk, rand32());
			run_cycle();
		end
		finish_test(4, "stray writes", start);

		start = errors;
		r = rand32();
		write_cfg(16'd1, fabric_cfg_pkg::BLK_SB, 32'h0000_ff55); // south carries logic
		write_cfg(16'd2, fabric_cfg_pkg::BLK_SB, 32'h00ff_0000); // east carries logic
		write_cfg(16'd1, fabric_cfg_pkg::BLK_CLB, {30'd0, fabric_cfg_pkg::OP_AND});
		write_cfg(16'd2, fabric_cfg_pkg::BLK_CLB, {30'd0, fabric_cfg_pkg::OP_AND});
		write_cfg(16'd1, fabric_cfg_pkg::BLK_CB0, {30'd0, r[1:0]});
		write_cfg(16'd1, fabric_cfg_pkg::BLK_CB1, {30'd0, r[3:2]});
		write_cfg(16'd2, fabric_cfg_pkg::BLK_CB0, {30'd0, r[5:4]});
		write_cfg(16'd2, fabric_cfg_pkg::BLK_CB1, {30'd0, r[7:6]});
		north_in <= 4'h0;
		south_in <= 4'hf;
		repeat (3) run_cycle();
		north_in <= 4'hf;
		lat = 0;
		seen = 1'b0;
		while (!seen && lat < 8) begin
			@(negedge clk);
			compare_outputs();
			if (t1_east_out == 4'hf) begin
				seen = 1'b1;
			end else begin
				@(posedge clk);
				model_edge();
				lat++;
			end
		end
		@(posedge clk);
		model_edge();
		if (!seen) begin
			errors++;
			$display("t1_east_out never went high on the cross-tile path");
		end else if (lat != 2) begin
			errors++;
			$display("Fail t1_east_out latency: got %h expected %h", lat, 2);
		end
		r = rand32();
		write_cfg(16'd1, fabric_cfg_pkg::BLK_CLB, {30'd0, r[1:0]});
		write_cfg(16'd2, fabric_cfg_pkg::BLK_CLB, {30'd0, r[3:2]});
		repeat (20) begin
			drive_random_inputs();
			run_cycle();
		end
		finish_test(5, "cross-tile path", start);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin : watchdog
		int n;
		for (n = 0; n < 3000; n++) begin
			@(posedge clk);
		end
		$display("simulation ran out of time after %0d cycles", n);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/fabric_geom_pkg.sv
rtl/fabric_cfg_pkg.sv
rtl/connect_box.sv
rtl/switch_box_left.sv
rtl/clb.sv
rtl/pe_tile_left.sv
rtl/fabric_column.sv
verification/tb_fabric_column.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_fabric_column
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
